// ==== build.f ====
common/decode_pkg.sv
decoder/imm_gen.sv
decoder/op_type_decode.sv
decoder/inst_decoder.sv
hdl/decode_buffer.sv
hdl/decode_stage.sv
bench/tb_clock.sv
bench/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - common/decode_pkg.sv
      - decoder/imm_gen.sv
      - decoder/op_type_decode.sv
      - decoder/inst_decoder.sv
      - hdl/decode_buffer.sv
      - hdl/decode_stage.sv
  - target: any(test, simulation)
    files:
      - bench/tb_clock.sv
      - bench/decode_stage_tb.sv

// ==== bench/decode_stage_tb.sv ====
/* Decode stage testbench
   Random instruction stream with stalls, reference decoder and assertion checks */
`timescale 1ns/1ns

module decode_stage_tb;
    import decode_pkg::*;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 5;  // Both sides stall up to half the time

    logic   clk, arst_n;
    logic   fetch_valid, fetch_ready, uop_valid, uop_ready;
    fetch_t fetch;
    uop_t   uop;
    sched_t sched;

    logic [31:0] rng_state = 32'hfcf0;
    uop_t        exp_q [$];
    uop_t        exp_head = '0;
    int          exp_cnt = 0;
    int          sent_cnt = 0;
    int          recv_cnt = 0;
    int          err_cnt = 0;
    int          cycles = 0;
    logic        exp_unlock;

    tb_clock clock_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    decode_stage decode_stage_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .uop_valid   (uop_valid),
        .uop_ready   (uop_ready),
        .uop         (uop),
        .sched       (sched)
    );

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // One random instruction from one of 16 classes
    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        logic [31:0] r;
        w = xorshift32();
        r = xorshift32();
        case (r[3:0])
            4'd0:      w = {1'b0, w[30], 5'b0, w[24:7], INST_R};
            4'd1:      w = {7'h01, w[24:7], INST_R};
            4'd2, 4'd3: w[6:0] = INST_I;
            4'd4:      w[6:0] = INST_LUI;
            4'd5:      w[6:0] = INST_AUIPC;
            4'd6:      w[6:0] = INST_JAL;
            4'd7:      w[6:0] = INST_JALR;
            4'd8: begin
                w[13] = w[13] & w[14];  // funct3 2 and 3 are not branches
                w[6:0] = INST_B;
            end
            4'd9:      w[6:0] = INST_L;
            4'd10:     w[6:0] = INST_S;
            4'd11:     w[6:0] = INST_FENCE;
            4'd12: begin
                if (w[13:12] == 2'b00)
                    w[12] = 1'b1;
                w[6:0] = INST_SYS;
            end
            4'd13: begin
                case (r[6:4])
                    3'd1:    w[31:20] = 12'h001;
                    3'd2:    w[31:20] = 12'h002;
                    3'd3:    w[31:20] = 12'h102;
                    3'd4:    w[31:20] = 12'h302;
                    default: w[31:20] = 12'h000;
                endcase
                w[14:12] = 3'b000;
                w[6:0] = INST_SYS;
            end
            4'd14:     w = {7'h00, w[24:15], 3'(r[6:4] % 3'd6), w[11:7], INST_EXT1};
            default: begin
                // Unused encodings
                if (r[5:4] == 2'd0)
                    w[6:0] = 7'h7f;
                else if (r[5:4] == 2'd1)
                    w = {7'h00, w[24:15], 2'b11, w[12:7], INST_EXT1};
                else
                    w = {1'b1, w[30:7], INST_EXT1};
            end
        endcase
        return w;
    endfunction

    function automatic fetch_t make_fetch();
        fetch_t f;
        logic [31:0] r;
        logic [31:0] p;
        r = xorshift32();
        p = xorshift32();
        f.wid   = r[WID_BITS-1:0];
        f.tmask = r[8 +: NUM_THREADS];
        f.pc    = {p[31:2], 2'b00};
        f.instr = make_instr();
        return f;
    endfunction

    function automatic alu_op_e alu_of(logic [2:0] f3, logic alt, logic reg_form);
        case (f3)
            3'd0:    return (alt && reg_form) ? SUB : ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return alt ? SRA : SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    // Expected micro-op straight from the RISC-V field layouts
    function automatic uop_t ref_uop(fetch_t f);
        uop_t        u;
        logic [31:0] w, imm_i, imm_s, imm_b, imm_u, imm_j;
        logic [2:0]  f3;
        logic        rd_on, rs1_on, rs2_on, ok;
        w  = f.instr;
        f3 = w[14:12];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        u = '0;
        {rd_on, rs1_on, rs2_on} = 3'b000;
        ok = 1'b1;
        case (w[6:0])
            INST_R: begin
                {rd_on, rs1_on, rs2_on} = 3'b111;
                if (w[31:25] == 7'h01) begin
                    u.op_args.xtype = ALU_MULDIV;
                    u.op_type = {1'b0, f3};
                end else begin
                    u.op_type = alu_of(f3, w[30], 1'b1);
                end
            end
            INST_I: begin
                {rd_on, rs1_on} = 2'b11;
                u.op_type = alu_of(f3, w[30], 1'b0);
                u.op_args.use_imm = 1'b1;
                u.op_args.imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, w[24:20]} : imm_i;
            end
            INST_LUI, INST_AUIPC: begin
                rd_on = 1'b1;
                u.op_type = (w[6:0] == INST_LUI) ? LUI : AUIPC;
                u.op_args.use_pc  = (w[6:0] == INST_AUIPC);
                u.op_args.use_imm = 1'b1;
                u.op_args.imm = imm_u;
            end
            INST_JAL, INST_JALR, INST_B: begin
                u.op_args.xtype = ALU_BRANCH;
                if (w[6:0] == INST_JAL) begin
                    rd_on = 1'b1;
                    u.op_type = JAL;
                    u.op_args.use_pc = 1'b1;
                    u.op_args.imm = imm_j;
                end else if (w[6:0] == INST_JALR) begin
                    {rd_on, rs1_on} = 2'b11;
                    u.op_type = JALR;
                    u.op_args.imm = imm_i;
                end else begin
                    {rs1_on, rs2_on} = 2'b11;
                    u.op_type = (f3 == 3'd1) ? BNE : (f3 == 3'd4) ? BLT :
                                (f3 == 3'd5) ? BGE : (f3 == 3'd6) ? BLTU :
                                (f3 == 3'd7) ? BGEU : BEQ;
                    u.op_args.use_pc = 1'b1;
                    u.op_args.imm = imm_b;
                end
            end
            INST_L: begin
                {rd_on, rs1_on} = 2'b11;
                u.ex_type = EX_LSU;
                u.op_type = {1'b0, f3};
                u.op_args.imm = imm_i;
            end
            INST_S: begin
                {rs1_on, rs2_on} = 2'b11;
                u.ex_type = EX_LSU;
                u.op_type = {1'b1, f3};
                u.op_args.imm = imm_s;
            end
            INST_FENCE: begin
                u.ex_type = EX_LSU;
                u.op_type = 4'd8;
            end
            INST_SYS: begin
                rd_on = 1'b1;
                if (f3[1:0] != 2'b00) begin
                    u.ex_type = EX_SFU;
                    u.op_type = (f3[1:0] == 2'd1) ? CSRRW : (f3[1:0] == 2'd2) ? CSRRS : CSRRC;
                    u.op_args.csr_addr = w[31:20];
                    u.op_args.use_imm  = f3[2];
                    u.op_args.imm = f3[2] ? {27'b0, w[19:15]} : '0;
                    rs1_on = !f3[2];
                end else begin
                    u.op_type = (w[31:20] == 12'h001) ? EBREAK : (w[31:20] == 12'h002) ? URET :
                                (w[31:20] == 12'h102) ? SRET : (w[31:20] == 12'h302) ? MRET :
                                ECALL;
                    u.op_args.xtype  = ALU_BRANCH;
                    u.op_args.use_pc = 1'b1;
                    u.op_args.imm = 32'd4;
                end
            end
            INST_EXT1: begin
                ok = (w[31:25] == 7'h00) && (f3 <= 3'd5);
                u.ex_type = EX_SFU;
                rs1_on = 1'b1;
                case (f3)
                    3'd0: u.op_type = TMC;
                    3'd1: begin
                        u.op_type = WSPAWN;
                        rs2_on = 1'b1;
                    end
                    3'd2: begin
                        u.op_type = SPLIT;
                        rd_on = 1'b1;
                        u.op_args.is_neg = w[20];
                    end
                    3'd3: u.op_type = JOIN;
                    3'd4: begin
                        u.op_type = BAR;
                        rs2_on = 1'b1;
                    end
                    default: begin
                        u.op_type = PRED;
                        rs2_on = 1'b1;
                        u.op_args.is_neg = w[7];  // rd bit 0
                    end
                endcase
            end
            default: ok = 1'b0;
        endcase
        if (ok) begin
            u.wid     = f.wid;
            u.tmask   = f.tmask;
            u.pc      = f.pc;
            u.wb      = rd_on && (w[11:7] != 5'd0);
            u.used_rs = {rs2_on, rs1_on};
            u.rd      = rd_on ? w[11:7] : '0;
            u.rs1     = rs1_on ? w[19:15] : '0;
            u.rs2     = rs2_on ? w[24:20] : '0;
        end else begin
            u = '0;
        end
        return u;
    endfunction

    // Warp stays locked on control flow, traps and warp control
    function automatic logic ref_unlock(logic [31:0] w);
        case (w[6:0])
            INST_JAL, INST_JALR, INST_B: return 1'b0;
            INST_SYS:  return w[13:12] != 2'b00;
            INST_EXT1: return !(w[31:25] == 7'h00 && w[14:12] <= 3'd5);
            default:   return 1'b1;
        endcase
    endfunction

    task automatic field_mismatch(input string what);
        err_cnt++;
        $display("FAIL %0t: %s", $time, what);
    endtask

    task automatic flow_error(input string what);
        err_cnt++;
        $display("%s at %0t", what, $time);
    endtask

    assign exp_unlock = ref_unlock(fetch.instr);

    // Scoreboard
    always @(posedge clk) begin
        if (arst_n) begin
            if (uop_valid && uop_ready) begin
                if (exp_q.size() != 0)
                    void'(exp_q.pop_front());
                recv_cnt <= recv_cnt + 1;
            end
            if (fetch_valid && fetch_ready)
                exp_q.push_back(ref_uop(fetch));
            exp_cnt  <= exp_q.size();
            exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
        end
    end

    rst_idle: assert property (@(posedge clk)
        !arst_n |-> !uop_valid && !sched.valid && fetch_ready)
        else field_mismatch("outputs active in reset");
    no_extra: assert property (@(posedge clk) disable iff (!arst_n) exp_cnt == 0 |-> !uop_valid)
        else flow_error("Extra micro-op presented");
    no_loss: assert property (@(posedge clk) disable iff (!arst_n) exp_cnt != 0 |-> uop_valid)
        else flow_error("Accepted micro-op missing");
    op_match: assert property (@(posedge clk) disable iff (!arst_n) uop_valid |->
        uop.ex_type == exp_head.ex_type && uop.op_type == exp_head.op_type)
        else field_mismatch("ex_type/op_type");
    args_match: assert property (@(posedge clk) disable iff (!arst_n) uop_valid |->
        uop.op_args == exp_head.op_args)
        else field_mismatch("op_args");
    regs_match: assert property (@(posedge clk) disable iff (!arst_n) uop_valid |->
        uop.wb == exp_head.wb && uop.used_rs == exp_head.used_rs && uop.rd == exp_head.rd
        && uop.rs1 == exp_head.rs1 && uop.rs2 == exp_head.rs2)
        else field_mismatch("wb/used_rs/registers");
    meta_match: assert property (@(posedge clk) disable iff (!arst_n) uop_valid |->
        uop.wid == exp_head.wid && uop.tmask == exp_head.tmask && uop.pc == exp_head.pc)
        else field_mismatch("wid/tmask/pc");
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        uop_valid && !uop_ready |=> uop_valid && $stable(uop))
        else field_mismatch("uop changed while stalled");
    full_ready: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_ready == (exp_cnt < BUF_DEPTH))
        else field_mismatch("fetch_ready");
    sched_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        sched.valid == (fetch_valid && exp_cnt < BUF_DEPTH))
        else field_mismatch("sched.valid");
    sched_fields: assert property (@(posedge clk) disable iff (!arst_n) sched.valid |->
        sched.wid == fetch.wid && sched.unlock == exp_unlock)
        else field_mismatch("sched.wid/unlock");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d micro-ops received",
                     cycles, recv_cnt, NUM_INSTR);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        fetch_valid = 1'b0;
        fetch       = '0;
        uop_ready   = 1'b0;
        @(posedge arst_n);
        while (sent_cnt < NUM_INSTR) begin
            @(posedge clk);
            r = xorshift32();
            if (fetch_valid && fetch_ready)
                sent_cnt++;
            if (!fetch_valid || fetch_ready) begin
                if (sent_cnt < NUM_INSTR && r[0]) begin
                    fetch_valid <= 1'b1;
                    fetch       <= make_fetch();
                end else begin
                    fetch_valid <= 1'b0;
                end
            end
            uop_ready <= r[1];
        end
        uop_ready <= 1'b1;  // Drain
        while (recv_cnt < NUM_INSTR)
            @(posedge clk);
        repeat (3) @(posedge clk);
        $display("Done: %0d sent, %0d received, %0d errors", sent_cnt, recv_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
/* Testbench clock and reset
   100 ns clock, reset held low for the first 5 cycles */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    end

    always #50 clk = ~clk;

endmodule

// ==== hdl/decode_stage.sv ====
/* Instruction decode stage
   Decoder followed by a two-entry micro-op buffer */
`timescale 1ns/1ns

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fetch_valid,
    output logic               fetch_ready,
    input  decode_pkg::fetch_t fetch,
    output logic               uop_valid,
    input  logic               uop_ready,
    output decode_pkg::uop_t   uop,
    output decode_pkg::sched_t sched
);
    import decode_pkg::*;

    uop_t dec_uop;

    inst_decoder inst_decoder_i (
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .buf_ready   (fetch_ready),
        .uop         (dec_uop),
        .sched       (sched)
    );

    decode_buffer decode_buffer_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_uop    (dec_uop),
        .out_valid (uop_valid),
        .out_ready (uop_ready),
        .out_uop   (uop)
    );

endmodule

// ==== hdl/decode_buffer.sv ====
/* Micro-op elastic buffer
   Small circular FIFO with valid/ready on both sides */
`timescale 1ns/1ns

module decode_buffer (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  decode_pkg::uop_t in_uop,
    output logic             out_valid,
    input  logic             out_ready,
    output decode_pkg::uop_t out_uop
);
    import decode_pkg::*;

    uop_t mem [BUF_DEPTH];
    logic [$clog2(BUF_DEPTH)-1:0]   wr_ptr, rd_ptr;
    logic [$clog2(BUF_DEPTH+1)-1:0] count;

    wire push = in_valid && in_ready;
    wire pop  = out_valid && out_ready;

    assign in_ready  = (count != BUF_DEPTH);
    assign out_valid = (count != '0);
    assign out_uop   = mem[rd_ptr];  // Head entry

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == BUF_DEPTH-1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == BUF_DEPTH-1) ? '0 : rd_ptr + 1'b1;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_uop;
    end

    count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= BUF_DEPTH);

    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_uop));

endmodule

// ==== decoder/inst_decoder.sv ====
/* Instruction decoder
   Turns a fetched word into a typed micro-op and notifies the warp scheduler */
`timescale 1ns/1ns

module inst_decoder (
    input  decode_pkg::fetch_t fetch,
    input  logic               fetch_valid,
    input  logic               buf_ready,
    output decode_pkg::uop_t   uop,
    output decode_pkg::sched_t sched
);
    import decode_pkg::*;

    logic [XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    alu_op_e  alu_op;
    br_op_e   br_op;
    br_op_e   sys_op;
    m_op_e    m_op;
    sfu_op_e  csr_op;

    ex_type_e           ex_type;
    logic [OP_BITS-1:0] op_type;
    op_args_t           op_args;
    logic use_rd, use_rs1, use_rs2;
    logic is_wstall;
    logic known;

    wire [XLEN-1:0]     instr  = fetch.instr;
    wire [6:0]          opcode = instr[6:0];
    wire [2:0]          funct3 = instr[14:12];
    wire [6:0]          funct7 = instr[31:25];
    wire [REG_BITS-1:0] rd     = instr[11:7];
    wire [REG_BITS-1:0] rs1    = instr[19:15];
    wire [REG_BITS-1:0] rs2    = instr[24:20];

    imm_gen imm_gen_i (
        .instr (instr),
        .i_imm (i_imm),
        .s_imm (s_imm),
        .b_imm (b_imm),
        .u_imm (u_imm),
        .j_imm (j_imm)
    );

    op_type_decode op_type_decode_i (
        .instr  (instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op),
        .m_op   (m_op),
        .csr_op (csr_op)
    );

    always_comb begin
        ex_type   = EX_ALU;
        op_type   = '0;
        op_args   = '0;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_wstall = 1'b0;
        known     = 1'b1;

        case (opcode)
            INST_I: begin
                op_type = alu_op;
                op_args.use_imm = 1'b1;
                op_args.imm = i_imm;
                {use_rd, use_rs1} = 2'b11;
            end
            INST_R: begin
                if (funct7 == 7'h01) begin
                    op_type = m_op;
                    op_args.xtype = ALU_MULDIV;
                end else begin
                    op_type = alu_op;
                end
                {use_rd, use_rs1, use_rs2} = 3'b111;
            end
            INST_LUI, INST_AUIPC: begin
                op_type = (opcode == INST_LUI) ? LUI : AUIPC;
                op_args.use_pc  = (opcode == INST_AUIPC);
                op_args.use_imm = 1'b1;
                op_args.imm = u_imm;
                use_rd = 1'b1;
            end
            INST_JAL: begin
                op_type = JAL;
                op_args.xtype  = ALU_BRANCH;
                op_args.use_pc = 1'b1;
                op_args.imm = j_imm;
                is_wstall = 1'b1;
                use_rd = 1'b1;
            end
            INST_JALR: begin
                op_type = JALR;
                op_args.xtype = ALU_BRANCH;
                op_args.imm = i_imm;
                is_wstall = 1'b1;
                {use_rd, use_rs1} = 2'b11;
            end
            INST_B: begin
                op_type = br_op;
                op_args.xtype  = ALU_BRANCH;
                op_args.use_pc = 1'b1;
                op_args.imm = b_imm;
                is_wstall = 1'b1;
                {use_rs1, use_rs2} = 2'b11;
            end
            INST_L: begin
                ex_type = EX_LSU;
                op_type = {1'b0, funct3};
                op_args.imm = i_imm;
                {use_rd, use_rs1} = 2'b11;
            end
            INST_S: begin
                ex_type = EX_LSU;
                op_type = {1'b1, funct3};
                op_args.imm = s_imm;
                {use_rs1, use_rs2} = 2'b11;
            end
            INST_FENCE: begin
                ex_type = EX_LSU;
                op_type = OP_BITS'(8);
            end
            INST_SYS: begin
                use_rd = 1'b1;
                if (funct3[1:0] != 2'b00) begin
                    ex_type = EX_SFU;
                    op_type = csr_op;
                    op_args.csr_addr = instr[31:20];
                    op_args.use_imm  = funct3[2];
                    if (funct3[2])
                        op_args.imm = XLEN'(rs1);  // Immediate CSR forms carry uimm in rs1
                    else
                        use_rs1 = 1'b1;
                end else begin
                    op_type = sys_op;
                    op_args.xtype  = ALU_BRANCH;
                    op_args.use_pc = 1'b1;
                    op_args.imm = XLEN'(4);
                    is_wstall = 1'b1;
                end
            end
            INST_EXT1: begin
                ex_type   = EX_SFU;
                is_wstall = 1'b1;
                use_rs1   = 1'b1;
                case (funct3)
                    3'h0: op_type = TMC;
                    3'h1: begin
                        op_type = WSPAWN;
                        use_rs2 = 1'b1;
                    end
                    3'h2: begin
                        op_type = SPLIT;
                        op_args.is_neg = rs2[0];
                        use_rd = 1'b1;
                    end
                    3'h3: op_type = JOIN;
                    3'h4: begin
                        op_type = BAR;
                        use_rs2 = 1'b1;
                    end
                    3'h5: begin
                        op_type = PRED;
                        op_args.is_neg = rd[0];
                        use_rs2 = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
                if (funct7 != 7'h00)
                    known = 1'b0;
                if (!known) begin
                    is_wstall = 1'b0;  // Unknown words never hold the warp
                end
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        uop = '0;
        if (known) begin
            uop.wid     = fetch.wid;
            uop.tmask   = fetch.tmask;
            uop.pc      = fetch.pc;
            uop.ex_type = ex_type;
            uop.op_type = op_type;
            uop.op_args = op_args;
            uop.wb      = use_rd && (rd != '0);  // x0 writes are dropped
            uop.used_rs = {use_rs2, use_rs1};
            uop.rd      = use_rd  ? rd  : '0;
            uop.rs1     = use_rs1 ? rs1 : '0;
            uop.rs2     = use_rs2 ? rs2 : '0;
        end
    end

    assign sched.valid  = fetch_valid && buf_ready;
    assign sched.wid    = fetch.wid;
    assign sched.unlock = ~is_wstall;

    always_comb begin
        wb_not_x0: assert final (!(uop.wb && (uop.rd == '0)));
    end

endmodule

// ==== decoder/op_type_decode.sv ====
/* Operation field decoder
   Maps funct3, funct7 and the system field to ALU, branch, system, M and CSR codes */
`timescale 1ns/1ns

module op_type_decode (
    input  logic [decode_pkg::XLEN-1:0] instr,
    output decode_pkg::alu_op_e         alu_op,
    output decode_pkg::br_op_e          br_op,
    output decode_pkg::br_op_e          sys_op,
    output decode_pkg::m_op_e           m_op,
    output decode_pkg::sfu_op_e         csr_op
);
    import decode_pkg::*;

    wire [2:0]  funct3  = instr[14:12];
    wire        f7_bit5 = instr[30];
    wire        is_reg  = instr[5];   // Register form, not immediate
    wire [11:0] sys_fld = instr[31:20];

    always_comb begin
        case (funct3)
            3'h0:    alu_op = (is_reg && f7_bit5) ? SUB : ADD;
            3'h1:    alu_op = SLL;
            3'h2:    alu_op = SLT;
            3'h3:    alu_op = SLTU;
            3'h4:    alu_op = XOR;
            3'h5:    alu_op = f7_bit5 ? SRA : SRL;
            3'h6:    alu_op = OR;
            default: alu_op = AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h1:    br_op = BNE;
            3'h4:    br_op = BLT;
            3'h5:    br_op = BGE;
            3'h6:    br_op = BLTU;
            3'h7:    br_op = BGEU;
            default: br_op = BEQ;
        endcase
    end

    always_comb begin
        case (sys_fld)
            12'h001: sys_op = EBREAK;
            12'h002: sys_op = URET;
            12'h102: sys_op = SRET;
            12'h302: sys_op = MRET;
            default: sys_op = ECALL;
        endcase
    end

    assign m_op = m_op_e'(funct3);  // M ops follow funct3 directly

    always_comb begin
        case (funct3[1:0])
            2'd2:    csr_op = CSRRS;
            2'd3:    csr_op = CSRRC;
            default: csr_op = CSRRW;
        endcase
    end

endmodule

// ==== decoder/imm_gen.sv ====
/* Immediate generator
   Builds the sign-extended I, S, B, U and J immediates of an instruction */
`timescale 1ns/1ns

module imm_gen (
    input  logic [decode_pkg::XLEN-1:0] instr,
    output logic [decode_pkg::XLEN-1:0] i_imm,
    output logic [decode_pkg::XLEN-1:0] s_imm,
    output logic [decode_pkg::XLEN-1:0] b_imm,
    output logic [decode_pkg::XLEN-1:0] u_imm,
    output logic [decode_pkg::XLEN-1:0] j_imm
);
    import decode_pkg::*;

    // SLLI, SRLI, SRAI carry a plain shift amount
    wire is_shift = (instr[6:0] == INST_I) && (instr[13:12] == 2'b01);

    assign i_imm = is_shift ? XLEN'(instr[24:20])
                            : {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign s_imm = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        u_low_zero: assert final (u_imm[11:0] == '0);
    end

endmodule

// ==== common/decode_pkg.sv ====
/* Decode stage definitions
   Widths, instruction encodings, operation codes and the pipeline structs */
package decode_pkg;

    localparam int XLEN        = 32;
    localparam int NUM_WARPS   = 4;
    localparam int WID_BITS    = $clog2(NUM_WARPS);
    localparam int NUM_THREADS = 4;
    localparam int REG_BITS    = 5;
    localparam int OP_BITS     = 4;
    localparam int BUF_DEPTH   = 2;

    // Major opcodes, RV32 encodings plus the custom-0 slot
    typedef enum logic [6:0] {
        INST_L     = 7'b0000011,
        INST_EXT1  = 7'b0001011,
        INST_FENCE = 7'b0001111,
        INST_I     = 7'b0010011,
        INST_AUIPC = 7'b0010111,
        INST_S     = 7'b0100011,
        INST_R     = 7'b0110011,
        INST_LUI   = 7'b0110111,
        INST_B     = 7'b1100011,
        INST_JALR  = 7'b1100111,
        INST_JAL   = 7'b1101111,
        INST_SYS   = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        EX_ALU,
        EX_LSU,
        EX_SFU
    } ex_type_e;

    typedef enum logic [1:0] {
        ALU_ARITH,
        ALU_BRANCH,
        ALU_MULDIV
    } alu_xtype_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI, AUIPC
    } alu_op_e;

    // Branches, jumps and the trap/return group
    typedef enum logic [3:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR, ECALL, EBREAK, URET, SRET, MRET
    } br_op_e;

    typedef enum logic [3:0] {
        MUL    = 4'd0,
        MULH   = 4'd1,
        MULHSU = 4'd2,
        MULHU  = 4'd3,
        DIV    = 4'd4,
        DIVU   = 4'd5,
        REM    = 4'd6,
        REMU   = 4'd7
    } m_op_e;

    typedef enum logic [3:0] {
        TMC, WSPAWN, SPLIT, JOIN, BAR, PRED, CSRRW, CSRRS, CSRRC
    } sfu_op_e;

    typedef struct packed {
        logic [WID_BITS-1:0]    wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        instr;
    } fetch_t;

    typedef struct packed {
        alu_xtype_e      xtype;
        logic            use_pc;
        logic            use_imm;
        logic [XLEN-1:0] imm;
        logic [11:0]     csr_addr;
        logic            is_neg;   // Inverted predicate for SPLIT and PRED
    } op_args_t;

    typedef struct packed {
        logic [WID_BITS-1:0]    wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        ex_type_e               ex_type;
        logic [OP_BITS-1:0]     op_type;
        op_args_t               op_args;
        logic                   wb;
        logic [1:0]             used_rs;  // rs2, rs1
        logic [REG_BITS-1:0]    rd;
        logic [REG_BITS-1:0]    rs1;
        logic [REG_BITS-1:0]    rs2;
    } uop_t;

    typedef struct packed {
        logic                valid;
        logic [WID_BITS-1:0] wid;
        logic                unlock;
    } sched_t;

endpackage
